//--- source/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// queue entries, power of two so indices wrap on their own
`define ISSUE_DEPTH 32
// older lane 1, younger lane 0
`define ISSUE_LANES 2
`define REG_COUNT 32
`define WORD_BITS 32
// jal target, jr through it is a return
`define LINK_REG 31

`endif

//--- source/issue_pkg.sv
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // data word
    typedef logic [`WORD_BITS-1:0] word_t;
    // architectural register number
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    // issue queue slot
    typedef logic [$clog2(`ISSUE_DEPTH)-1:0] qidx_t;

    // operation class, only what the pairing rules look at
    typedef enum logic [3:0] {
        op_alu,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_branch,
        op_jump,
        op_jr,
        op_syscall,
        op_eret
    } op_t;

    // decoded instruction as it leaves decode
    typedef struct packed {
        logic        valid;
        word_t       pc;
        op_t         op;
        reg_idx_t    ra1;
        reg_idx_t    ra2;
        reg_idx_t    rdst;
        logic        regwrite;
        logic [15:0] imm;
        logic        is_exc;
    } inst_t;

    // writeback result, also used for forwarding
    typedef struct packed {
        logic     valid;
        reg_idx_t rdst;
        word_t    data;
    } fwd_t;

    // instruction handed to execute with its operands
    typedef struct packed {
        logic        valid;
        word_t       pc;
        op_t         op;
        reg_idx_t    rdst;
        logic        regwrite;
        logic [15:0] imm;
        word_t       rd1;
        word_t       rd2;
        logic        is_slot;
        logic        is_jr_ra;
    } issued_t;

endpackage

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module register_file
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  fwd_t     [1:0] wb,
    input  reg_idx_t [3:0] ra,
    output word_t    [3:0] rd
);

    word_t regs [`REG_COUNT];

    // port 0 first so port 1 lands last on a collision
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                // r0 stays zero
                if (wb[p].valid && wb[p].rdst != '0) begin
                    regs[wb[p].rdst] <= wb[p].data;
                end
            end
        end
    end

    // combinational reads, no write-through
    // same-cycle results come from the operand selectors
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd[i] = (ra[i] == '0) ? '0 : regs[ra[i]];
        end
    end

endmodule

`default_nettype wire

//--- source/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module operand_select
    import issue_pkg::*;
(
    input  inst_t       cand,
    input  word_t       rf1,
    input  word_t       rf2,
    input  fwd_t  [1:0] wb,
    output word_t       rd1,
    output word_t       rd2,
    output logic        is_jr_ra
);

    // forward over register file, port 1 is the older result
    function automatic word_t resolve(reg_idx_t src, word_t rf, fwd_t [1:0] fw);
        word_t value;
        value = rf;
        if (fw[0].valid && src != '0 && fw[0].rdst == src) begin
            value = fw[0].data;
        end
        if (fw[1].valid && src != '0 && fw[1].rdst == src) begin
            value = fw[1].data;
        end
        return value;
    endfunction

    assign rd1 = resolve(cand.ra1, rf1, wb);
    assign rd2 = resolve(cand.ra2, rf2, wb);

    // return through the link register, for the return stack
    assign is_jr_ra = cand.valid && cand.op == op_jr &&
                      cand.ra1 == reg_idx_t'(`LINK_REG);

endmodule

`default_nettype wire

//--- source/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_queue
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  inst_t [1:0] dec,
    input  logic        stall,
    input  logic        flush,
    output inst_t [1:0] cand,
    output logic  [1:0] issue_en,
    output logic        is_slot,
    output logic        overflow
);

    // payload storage, entries between head and tail are valid
    inst_t entries [`ISSUE_DEPTH];

    qidx_t      head;
    qidx_t      tail;
    qidx_t      used;
    logic       accept;
    // incoming pair packed to the front, lane 1 first
    inst_t      in_first;
    inst_t      in_second;
    logic [1:0] in_count;
    logic [1:0] out_count;

    logic older_branch;
    logic older_excl;
    logic reg_dep;
    logic md_pair;
    logic hilo_dep;
    logic pair_ok;

    function automatic logic is_muldiv(op_t op);
        return op inside {op_mult, op_multu, op_div, op_divu};
    endfunction

    // branch, jump or jr, all carry a delay slot
    function automatic logic is_ctrl(op_t op);
        return op inside {op_branch, op_jump, op_jr};
    endfunction

    function automatic logic writes_hi(op_t op);
        return is_muldiv(op) || op == op_mthi;
    endfunction

    function automatic logic writes_lo(op_t op);
        return is_muldiv(op) || op == op_mtlo;
    endfunction

    assign used = qidx_t'(tail - head);

    // fewer than three free slots left
    assign overflow = (qidx_t'(tail + 1) == head) || (qidx_t'(tail + 2) == head);
    assign accept   = !stall && !flush && !overflow;

    always_comb begin
        in_first  = dec[1].valid ? dec[1] : dec[0];
        in_second = dec[1].valid ? dec[0] : '0;
        // nothing comes in while blocked, decode holds the pair
        in_first.valid  = in_first.valid && accept;
        in_second.valid = in_second.valid && accept;
    end

    assign in_count = {1'b0, in_first.valid} + {1'b0, in_second.valid};

    // two oldest of queue contents followed by the incoming pair
    always_comb begin
        if (used == '0) begin
            cand[1] = in_first;
            cand[0] = in_second;
        end else if (used == qidx_t'(1)) begin
            cand[1] = entries[head];
            cand[0] = in_first;
        end else begin
            cand[1] = entries[head];
            cand[0] = entries[qidx_t'(head + 1)];
        end
    end

    assign older_branch = is_ctrl(cand[1].op);
    assign older_excl   = cand[1].is_exc || cand[1].op inside {op_syscall, op_eret};

    // younger reads what older writes, r0 never counts
    assign reg_dep = cand[1].regwrite && cand[1].rdst != '0 &&
                     (cand[0].ra1 == cand[1].rdst || cand[0].ra2 == cand[1].rdst);

    // single mult/div unit
    assign md_pair = is_muldiv(cand[1].op) && is_muldiv(cand[0].op);

    assign hilo_dep = (writes_hi(cand[1].op) && cand[0].op == op_mfhi) ||
                      (writes_lo(cand[1].op) && cand[0].op == op_mflo);

    // delay slot may read the link register written by its jal
    assign pair_ok = cand[1].valid && cand[0].valid &&
                     !(reg_dep && !older_branch) &&
                     !md_pair && !hilo_dep &&
                     !is_ctrl(cand[0].op) && !older_excl;

    // a branch waits until its slot can go with it
    assign issue_en[1] = cand[1].valid && (!older_branch || pair_ok);
    assign issue_en[0] = issue_en[1] && pair_ok;
    assign is_slot     = older_branch && issue_en[1];

    assign out_count = {1'b0, issue_en[1]} + {1'b0, issue_en[0]};

    // incoming always lands at tail, head skips what issued at once
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (!stall) begin
                head <= qidx_t'(head + out_count);
            end
            tail <= qidx_t'(tail + in_count);
        end
    end

    always_ff @(posedge clk) begin
        if (in_first.valid) begin
            entries[tail] <= in_first;
        end
        if (in_second.valid) begin
            entries[qidx_t'(tail + 1)] <= in_second;
        end
    end

endmodule

`default_nettype wire

//--- source/issue_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_register
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  inst_t   [1:0] cand,
    input  logic    [1:0] issue_en,
    input  logic          is_slot,
    input  word_t   [1:0] rd1,
    input  word_t   [1:0] rd2,
    input  logic    [1:0] is_jr_ra,
    output issued_t [1:0] iss
);

    issued_t [1:0] next_iss;

    always_comb begin
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            // payload passes through, valid says whether it counts
            next_iss[i].valid    = issue_en[i] && cand[i].valid;
            next_iss[i].pc       = cand[i].pc;
            next_iss[i].op       = cand[i].op;
            next_iss[i].rdst     = cand[i].rdst;
            next_iss[i].regwrite = cand[i].regwrite;
            next_iss[i].imm      = cand[i].imm;
            next_iss[i].rd1      = rd1[i];
            next_iss[i].rd2      = rd2[i];
            next_iss[i].is_slot  = 1'b0;
            next_iss[i].is_jr_ra = is_jr_ra[i];
        end
        // delay slot only ever sits in the younger lane
        next_iss[0].is_slot = is_slot && issue_en[0];
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            iss <= '0;
        end else if (!stall) begin
            iss <= next_iss;
        end
    end

endmodule

`default_nettype wire

//--- source/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_top
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  inst_t   [1:0] dec,
    input  fwd_t    [1:0] wb,
    input  logic          stall,
    input  logic          flush,
    output logic          overflow,
    output issued_t [1:0] iss
);

    inst_t    [1:0] cand;
    logic     [1:0] issue_en;
    logic           is_slot;
    // read ports, two per lane
    reg_idx_t [3:0] rf_ra;
    word_t    [3:0] rf_rd;
    word_t    [1:0] rd1;
    word_t    [1:0] rd2;
    logic     [1:0] is_jr_ra;

    issue_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .stall    (stall),
        .flush    (flush),
        .cand     (cand),
        .issue_en (issue_en),
        .is_slot  (is_slot),
        .overflow (overflow)
    );

    register_file u_regs (
        .clk   (clk),
        .reset (reset),
        .wb    (wb),
        .ra    (rf_ra),
        .rd    (rf_rd)
    );

    genvar lane;
    generate
        for (lane = 0; lane < `ISSUE_LANES; lane++) begin : g_lane
            assign rf_ra[2*lane]   = cand[lane].ra1;
            assign rf_ra[2*lane+1] = cand[lane].ra2;

            operand_select u_sel (
                .cand     (cand[lane]),
                .rf1      (rf_rd[2*lane]),
                .rf2      (rf_rd[2*lane+1]),
                .wb       (wb),
                .rd1      (rd1[lane]),
                .rd2      (rd2[lane]),
                .is_jr_ra (is_jr_ra[lane])
            );
        end
    endgenerate

    issue_register u_iss (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .cand     (cand),
        .issue_en (issue_en),
        .is_slot  (is_slot),
        .rd1      (rd1),
        .rd2      (rd2),
        .is_jr_ra (is_jr_ra),
        .iss      (iss)
    );

endmodule

`default_nettype wire

//--- verification/tb_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module tb_issue_top
    import issue_pkg::*;
();

    localparam int MAX_LINES = 64;
    localparam int FIELDS = 33;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = 1000;

    logic          clk;
    logic          reset;
    inst_t   [1:0] dec;
    fwd_t    [1:0] wb;
    logic          stall;
    logic          flush;
    logic          overflow;
    issued_t [1:0] iss;

    // one row per stimulus line
    inst_t   [1:0] dec_tab [MAX_LINES];
    fwd_t    [1:0] wb_tab [MAX_LINES];
    logic          stall_tab [MAX_LINES];
    logic          flush_tab [MAX_LINES];
    issued_t [1:0] exp_tab [MAX_LINES];
    logic          ovf_tab [MAX_LINES];
    int            fields [FIELDS];
    int            line_count;
    int            iss_errors;
    int            ovf_errors;
    int            other_errors;

    issue_top dut (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .wb       (wb),
        .stall    (stall),
        .flush    (flush),
        .overflow (overflow),
        .iss      (iss)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // a nonzero rdst means the instruction writes it
    function automatic inst_t make_inst(int v, int pc, int op, int a1, int a2, int rdst);
        inst_t inst;
        inst          = '0;
        inst.valid    = v[0];
        inst.pc       = word_t'(pc);
        inst.op       = op_t'(op[3:0]);
        inst.ra1      = reg_idx_t'(a1);
        inst.ra2      = reg_idx_t'(a2);
        inst.rdst     = reg_idx_t'(rdst);
        inst.regwrite = (rdst != 0);
        return inst;
    endfunction

    function automatic fwd_t make_fwd(int v, int rdst, int data);
        fwd_t fw;
        fw.valid = v[0];
        fw.rdst  = reg_idx_t'(rdst);
        fw.data  = word_t'(data);
        return fw;
    endfunction

    // only the fields the stimulus file predicts
    function automatic issued_t make_expect(int v, int pc, int r1, int r2, int slot, int jr);
        issued_t ex;
        ex          = '0;
        ex.valid    = v[0];
        ex.pc       = word_t'(pc);
        ex.rd1      = word_t'(r1);
        ex.rd2      = word_t'(r2);
        ex.is_slot  = slot[0];
        ex.is_jr_ra = jr[0];
        return ex;
    endfunction

    // decoded fields of an expected lane come from the driven instruction with its pc
    task automatic attach_payload(input int row, input int lane);
        issued_t ex;
        logic    found;
        ex    = exp_tab[row][lane];
        found = 1'b0;
        for (int j = 0; j <= row; j++) begin
            for (int l = 0; l < `ISSUE_LANES; l++) begin
                if (!found && dec_tab[j][l].valid && dec_tab[j][l].pc == ex.pc) begin
                    ex.op       = dec_tab[j][l].op;
                    ex.rdst     = dec_tab[j][l].rdst;
                    ex.regwrite = dec_tab[j][l].regwrite;
                    ex.imm      = dec_tab[j][l].imm;
                    found       = 1'b1;
                end
            end
        end
        if (ex.valid && !found) begin
            other_errors++;
            $display("expected pc %h on stimulus row %0d was never driven", ex.pc, row);
        end
        exp_tab[row][lane] = ex;
    endtask

    // split on whitespace, every token is hex
    task automatic parse_fields(input string text, output int count);
        int start;
        int value;
        logic gap;
        count = 0;
        start = -1;
        for (int i = 0; i <= text.len(); i++) begin
            gap = (i == text.len()) || (text.getc(i) <= 8'h20);
            if (gap && start >= 0) begin
                void'($sscanf(text.substr(start, i - 1), "%h", value));
                if (count < FIELDS) begin
                    fields[count] = value;
                end
                count++;
                start = -1;
            end else if (!gap && start < 0) begin
                start = i;
            end
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int n;
        int raw;
        string text;
        fd = $fopen("verification/issue_stim.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file");
            return;
        end
        raw = 0;
        // bounded even if the file never reports its end
        while (!$feof(fd) && line_count < MAX_LINES && raw < 4 * MAX_LINES) begin
            raw++;
            text = "";
            void'($fgets(text, fd));
            parse_fields(text, n);
            if (n == 0 || text.substr(0, 0) == "#") begin
                continue;
            end
            if (n != FIELDS) begin
                other_errors++;
                $display("stimulus line %0d has %0d fields instead of %0d", raw, n, FIELDS);
                continue;
            end
            dec_tab[line_count][1] = make_inst(fields[0], fields[1], fields[2],
                                               fields[3], fields[4], fields[5]);
            dec_tab[line_count][0] = make_inst(fields[6], fields[7], fields[8],
                                               fields[9], fields[10], fields[11]);
            wb_tab[line_count][1]  = make_fwd(fields[12], fields[13], fields[14]);
            wb_tab[line_count][0]  = make_fwd(fields[15], fields[16], fields[17]);
            stall_tab[line_count]  = fields[18][0];
            flush_tab[line_count]  = fields[19][0];
            exp_tab[line_count][1] = make_expect(fields[20], fields[21], fields[22],
                                                 fields[23], fields[24], fields[25]);
            exp_tab[line_count][0] = make_expect(fields[26], fields[27], fields[28],
                                                 fields[29], fields[30], fields[31]);
            ovf_tab[line_count]    = fields[32][0];
            attach_payload(line_count, 1);
            attach_payload(line_count, 0);
            line_count++;
        end
        $fclose(fd);
        if (line_count == 0) begin
            other_errors++;
            $display("the stimulus file held no usable lines");
        end
    endtask

    task automatic drive_line(input int k);
        dec   <= dec_tab[k];
        wb    <= wb_tab[k];
        stall <= stall_tab[k];
        flush <= flush_tab[k];
    endtask

    task automatic drive_idle();
        dec   <= '0;
        wb    <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
    endtask

    // payload only matters when the lane is valid
    task automatic check_iss(input int lane, input issued_t got, input issued_t exp);
        if (got.valid !== exp.valid) begin
            iss_errors++;
            $display("Fail %0d ns: lane %0d valid %0b, expected %0b",
                     $time, lane, got.valid, exp.valid);
        end else if (exp.valid && (got.pc !== exp.pc || got.op !== exp.op ||
                     got.rdst !== exp.rdst || got.regwrite !== exp.regwrite ||
                     got.imm !== exp.imm || got.rd1 !== exp.rd1 ||
                     got.rd2 !== exp.rd2 || got.is_slot !== exp.is_slot ||
                     got.is_jr_ra !== exp.is_jr_ra)) begin
            iss_errors++;
            $display("Fail %0d ns: lane %0d pc %h op %0d rdst %0d wr %0b imm %h",
                     $time, lane, got.pc, got.op, got.rdst, got.regwrite, got.imm);
            $display("    rd1 %h rd2 %h slot %0b jr_ra %0b",
                     got.rd1, got.rd2, got.is_slot, got.is_jr_ra);
            $display("    expected pc %h op %0d rdst %0d wr %0b imm %h",
                     exp.pc, exp.op, exp.rdst, exp.regwrite, exp.imm);
            $display("    expected rd1 %h rd2 %h slot %0b jr_ra %0b",
                     exp.rd1, exp.rd2, exp.is_slot, exp.is_jr_ra);
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp);
        if (got !== exp) begin
            ovf_errors++;
            $display("Fail %0d ns: overflow %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic check_line(input issued_t [1:0] exp, input logic ovf);
        for (int lane = `ISSUE_LANES - 1; lane >= 0; lane--) begin
            check_iss(lane, iss[lane], exp[lane]);
        end
        check_overflow(overflow, ovf);
    endtask

    initial begin
        reset        = 1'b1;
        dec          = '0;
        wb           = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        line_count   = 0;
        iss_errors   = 0;
        ovf_errors   = 0;
        other_errors = 0;
        load_stimulus();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        // inputs go in at the edge, results of the line before are read at the falling edge
        for (int k = 0; k <= line_count; k++) begin
            @(posedge clk);
            if (k < line_count) begin
                drive_line(k);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (k == 0) begin
                // empty right after reset
                check_line('0, 1'b0);
            end else begin
                check_line(exp_tab[k-1], ovf_tab[k-1]);
            end
        end
        $display("errors: %0d issue, %0d overflow, %0d other",
                 iss_errors, ovf_errors, other_errors);
        if (iss_errors + ovf_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // hard stop if the run never reaches its end
    initial begin
        for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/issue_stim.txt
# dec1 v pc op ra1 ra2 rdst | dec0 same | wb1 v rdst data | wb0 same | stall flush
# then iss1 v pc rd1 rd2 is_slot is_jr_ra | iss0 same | overflow, all hex, op as op_t index
0 0 0 00 00 00  0 0 0 00 00 00  1 01 11  1 02 22  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  1 03 33  1 04 44  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  1 05 55  1 06 66  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  1 1f f0  1 07 77  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 100 0 01 02 08  1 104 0 03 04 09  0 00 00  0 00 00  0 0  1 100 11 22 0 0  1 104 33 44 0 0  0
1 108 0 01 02 0a  1 10c 0 0a 03 0b  0 00 00  0 00 00  0 0  1 108 11 22 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  1 0  1 108 11 22 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  0 0  1 10c 0 33 0 0  0 0 0 0 0 0  0
1 110 1 01 02 00  1 114 3 03 04 00  0 00 00  0 00 00  0 0  1 110 11 22 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  0 0  1 114 33 44 0 0  0 0 0 0 0 0  0
1 118 7 05 00 00  1 11c 5 00 00 0c  0 00 00  0 00 00  0 0  1 118 55 0 0 0  0 0 0 0 0 0  0
1 120 0 06 07 0d  1 124 0 01 02 0e  0 00 00  0 00 00  0 0  1 11c 0 0 0 0  1 120 66 77 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  0 0  1 124 11 22 0 0  0 0 0 0 0 0  0
1 128 0 01 02 0f  1 12c 9 03 04 00  0 00 00  0 00 00  0 0  1 128 11 22 0 0  0 0 0 0 0 0  0
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 130 0 01 05 10  0 0 0 00 00 00  0 00 00  0 00 00  0 0  1 12c 33 44 0 0  1 130 11 55 1 0  0
1 140 a 00 00 1f  1 144 0 1f 02 11  0 00 00  0 00 00  0 0  1 140 0 0 0 0  1 144 f0 22 1 0  0
1 148 b 1f 00 00  1 14c 0 03 04 00  0 00 00  0 00 00  0 0  1 148 f0 0 0 1  1 14c 33 44 1 0  0
1 150 0 01 02 12  1 154 0 03 04 13  1 02 a2  1 03 b3  0 0  1 150 11 a2 0 0  1 154 b3 44 0 0  0
1 158 0 04 05 14  1 15c 0 04 06 15  1 04 c4  1 04 d4  0 0  1 158 c4 55 0 0  1 15c c4 66 0 0  0
1 160 0 01 02 16  1 164 0 03 04 17  0 00 00  0 00 00  1 0  1 158 c4 55 0 0  1 15c c4 66 0 0  0
1 160 0 01 02 16  1 164 0 03 04 17  0 00 00  0 00 00  0 0  1 160 11 a2 0 0  1 164 b3 c4 0 0  0
1 200 9 01 02 00  1 204 9 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  0
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  1
1 208 0 01 02 00  1 20c 0 03 04 00  0 00 00  0 00 00  0 0  0 0 0 0 0 0  0 0 0 0 0 0  1
0 0 0 00 00 00  0 0 0 00 00 00  0 00 00  0 00 00  0 1  0 0 0 0 0 0  0 0 0 0 0 0  0
1 300 0 01 05 18  1 304 0 06 07 00  0 00 00  0 00 00  0 0  1 300 11 55 0 0  1 304 66 77 0 0  0

//--- files.f
+incdir+source
source/issue_pkg.sv
source/register_file.sv
source/operand_select.sv
source/issue_queue.sv
source/issue_register.sv
source/issue_top.sv
verification/tb_issue_top.sv

//--- run.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_issue_top -f files.f -o sim_issue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_issue)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
